// File: filelist.f
mips_debug_pkg.sv
uart_rx.sv
uart_tx.sv
debug_unit.sv
instr_mem.sv
accum_core.sv
mips_debug_top.sv
tb_mips_debug.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f filelist.f \
	--top-module tb_mips_debug --Mdir obj_dir -o tb_mips_debug
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_mips_debug > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$log"; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation PASSED"
exit 0

// File: tb_mips_debug.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_debug;

	import mips_debug_pkg::*;

	localparam int clks_per_bit    = 8;
	localparam int imem_addr_width = 6;
	localparam int imem_depth      = 2**imem_addr_width;
	localparam int report_timeout  = 3000;	// cycles allowed before a report byte starts

	typedef logic [imem_addr_width-1:0] addr_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        rx;
	logic        tx;
	logic [31:0] prog [imem_depth];	// program image as sent to the DUT
	int          prog_len;
	int          errors = 0;
	integer      seed = 89;

	always #2 clk = ~clk;

	mips_debug_top #(
		.clks_per_bit   (clks_per_bit),
		.imem_addr_width(imem_addr_width)
	) i_mips_debug_top (
		.clk  (clk),
		.reset(reset),
		.rx   (rx),
		.tx   (tx)
	);

	////////////////////////////////////////////////////////////////////////////
	// serial link helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic send_byte(input logic [7:0] data);
		@(negedge clk);
		rx = 1'b0;	// start bit
		repeat (clks_per_bit) @(negedge clk);
		for (int b = 0; b < 8; b++)
		begin
			rx = data[b];	// lsb first
			repeat (clks_per_bit) @(negedge clk);
		end
		rx = 1'b1;
		repeat (clks_per_bit) @(negedge clk);
	endtask

	task automatic recv_byte(input int limit, output logic [7:0] data, output logic ok);
		int waited;
		waited = 0;
		data = '0;
		@(negedge clk);
		while (tx !== 1'b0 && waited < limit)
		begin
			@(negedge clk);
			waited++;
		end
		ok = (tx === 1'b0);
		if (ok)
		begin
			repeat (clks_per_bit / 2) @(negedge clk);	// middle of the start bit
			for (int b = 0; b < 8; b++)
			begin
				repeat (clks_per_bit) @(negedge clk);
				data[b] = tx;
			end
			repeat (clks_per_bit) @(negedge clk);
			assert (tx === 1'b1) else
			begin
				errors++;
				$display("error at %0t ns: stop bit on tx is low", $time);
			end
		end
	endtask

	task automatic recv_word(output logic [31:0] word);
		logic [7:0] data;
		logic       ok;
		logic       lost;
		word = '0;
		lost = 1'b0;
		for (int b = 0; b < report_bytes && !lost; b++)
		begin
			recv_byte(report_timeout, data, ok);
			assert (ok) else
			begin
				errors++;
				$display("error at %0t ns: report byte %0d never started on tx", $time, b);
			end
			lost = !ok;
			word[8*b +: 8] = data;
		end
	endtask

	// the report can start before the command's stop bit is over
	task automatic command_with_report(input logic [7:0] cmd, output logic [31:0] acc);
		fork
			send_byte(cmd);
			recv_word(acc);
		join
	endtask

	task automatic check_acc(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else
		begin
			errors++;
			$display("mismatch at %0t ns: %s reported %h, expected %h",
				$time, what, got, expected);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// programs and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] make_word(input opcode_t op, input logic [25:0] field);
		return {op, field};
	endfunction

	task automatic build_random_program(input int n);
		logic [31:0] r;
		opcode_t     op;
		for (int i = 0; i < n; i++)
		begin
			r = $random(seed);
			if (r[16])
				op = op_addi;
			else
				op = op_xori;
			prog[addr_t'(i)] = make_word(op, {10'h000, r[15:0]});
		end
		prog[addr_t'(n)] = make_word(op_halt, '0);
		prog_len = n + 1;
	endtask

	task automatic load_program;
		send_byte(cmd_start);
		for (int i = 0; i < prog_len; i++)
		begin
			for (int b = 0; b < 4; b++)
				send_byte(prog[addr_t'(i)][8*b +: 8]);
		end
	endtask

	// accumulator after the given number of instructions with halt counted as one
	task automatic model_acc(input int steps, output logic [31:0] acc);
		addr_t       pc;
		logic [31:0] w;
		logic        halted;
		pc = '0;
		acc = '0;
		halted = 1'b0;
		for (int n = 0; n < steps && !halted; n++)
		begin
			w = prog[pc];
			case (w[31:26])
				op_addi:
				begin
					acc = acc + {{16{w[15]}}, w[15:0]};	// sign extended
					pc = pc + addr_t'(1);
				end
				op_xori:
				begin
					acc = acc ^ {16'h0000, w[15:0]};
					pc = pc + addr_t'(1);
				end
				op_jmp:
					pc = w[imem_addr_width-1:0];
				op_halt:
					halted = 1'b1;
				default:
					pc = pc + addr_t'(1);
			endcase
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic idle_stays_quiet;
		logic [7:0] data;
		logic       ok;
		for (int i = 0; i < 20 * clks_per_bit; i++)
		begin
			@(negedge clk);
			assert (tx === 1'b1) else
			begin
				errors++;
				$display("error at %0t ns: tx left the idle level after reset", $time);
			end
		end
		send_byte(8'h77);	// not a command
		recv_byte(20 * clks_per_bit, data, ok);
		assert (!ok) else
		begin
			errors++;
			$display("error at %0t ns: unknown byte in idle started a report", $time);
		end
	endtask

	task automatic continuous_run;
		logic [31:0] got;
		logic [31:0] expected;
		build_random_program(8);
		load_program();
		command_with_report(cmd_continuous, got);
		model_acc(imem_depth, expected);
		check_acc("continuous run", got, expected);
	endtask

	task automatic jump_skips;
		logic [31:0] r;
		logic [31:0] got;
		logic [31:0] expected;
		send_byte(cmd_reprogram);	// back to idle from waiting
		r = $random(seed);
		prog[0] = make_word(op_addi, {10'h000, r[15:0]});
		prog[1] = make_word(op_jmp, 26'd4);
		prog[2] = make_word(op_addi, {10'h000, 16'h7fff});	// jumped over
		prog[3] = make_word(op_addi, {10'h000, 16'h0001});	// jumped over
		r = $random(seed);
		prog[4] = make_word(op_xori, {10'h000, r[15:0]});
		prog[5] = make_word(op_addi, {10'h000, r[31:16]});
		prog[6] = make_word(op_halt, '0);
		prog_len = 7;
		load_program();
		command_with_report(cmd_continuous, got);
		model_acc(imem_depth, expected);
		check_acc("program with jmp", got, expected);
	endtask

	task automatic reprogram_clears;
		logic [31:0] r;
		logic [31:0] got;
		logic [31:0] expected;
		send_byte(cmd_reprogram);
		r = $random(seed);
		prog[0] = make_word(op_addi, {10'h000, r[15:0]});
		prog[1] = make_word(op_halt, '0);
		prog_len = 2;
		load_program();
		command_with_report(cmd_continuous, got);
		model_acc(imem_depth, expected);	// starts from zero
		check_acc("run after reprogram", got, expected);
	endtask

	// older words past the short program's halt stay in memory
	task automatic step_through;
		logic [31:0] got;
		logic [31:0] expected;
		send_byte(cmd_reprogram);
		build_random_program(3);
		load_program();
		send_byte(cmd_step_mode);
		for (int k = 1; k <= prog_len; k++)
		begin
			command_with_report(cmd_step, got);
			model_acc(k, expected);
			check_acc($sformatf("step %0d", k), got, expected);
		end
	endtask

	task automatic step_after_halt;
		logic [31:0] got;
		logic [31:0] expected;
		for (int k = 0; k < 2; k++)
		begin
			command_with_report(cmd_step, got);
			model_acc(imem_depth, expected);
			check_acc("step after halt", got, expected);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		rx = 1'b1;	// line idles high
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		idle_stays_quiet();
		continuous_run();
		jump_skips();
		reprogram_clears();
		step_through();
		step_after_halt();

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: mips_debug_top.sv
`timescale 1ns/10ps
`default_nettype none

module mips_debug_top #(
	parameter int clks_per_bit    = 8,
	parameter int imem_addr_width = 6
) (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx
);

	import mips_debug_pkg::*;

	rx_byte_t                   rx_byte;
	imem_wr_t                   imem_wr;
	core_status_t               status;
	logic                       tx_start;
	logic [7:0]                 tx_data;
	logic                       tx_busy;
	logic                       tx_done;
	logic                       run;
	logic                       clear;
	logic                       retire;
	logic [imem_addr_width-1:0] fetch_addr;
	logic [31:0]                fetch_data;

	////////////////////////////////////////////////////////////////////////////
	// serial link
	////////////////////////////////////////////////////////////////////////////

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) i_uart_rx (
		.clk    (clk),
		.reset  (reset),
		.rx     (rx),
		.rx_byte(rx_byte)
	);

	uart_tx #(
		.clks_per_bit(clks_per_bit)
	) i_uart_tx (
		.clk     (clk),
		.reset   (reset),
		.tx_start(tx_start),
		.tx_data (tx_data),
		.tx      (tx),
		.tx_busy (tx_busy),
		.tx_done (tx_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// debug control, program memory and core
	////////////////////////////////////////////////////////////////////////////

	debug_unit #(
		.imem_addr_width(imem_addr_width)
	) i_debug_unit (
		.clk     (clk),
		.reset   (reset),
		.rx_byte (rx_byte),
		.tx_busy (tx_busy),
		.tx_done (tx_done),
		.tx_start(tx_start),
		.tx_data (tx_data),
		.imem_wr (imem_wr),
		.run     (run),
		.clear   (clear),
		.retire  (retire),
		.status  (status)
	);

	instr_mem #(
		.imem_addr_width(imem_addr_width)
	) i_instr_mem (
		.clk       (clk),
		.imem_wr   (imem_wr),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data)
	);

	accum_core #(
		.imem_addr_width(imem_addr_width)
	) i_accum_core (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.clear     (clear),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data),
		.retire    (retire),
		.status    (status)
	);

endmodule

`default_nettype wire

// File: accum_core.sv
`timescale 1ns/10ps
`default_nettype none

module accum_core #(
	parameter int imem_addr_width = 6
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         run,
	input  logic                         clear,
	output logic [imem_addr_width-1:0]   fetch_addr,
	input  logic [31:0]                  fetch_data,
	output logic                         retire,
	output mips_debug_pkg::core_status_t status
);

	import mips_debug_pkg::*;

	logic [imem_addr_width-1:0] pc;
	logic [31:0]                acc;
	logic                       halted;
	logic                       exec_phase;	// 0 fetch, 1 execute
	opcode_t                    op;
	logic [31:0]                imm_sext;
	logic [31:0]                imm_zext;
	logic                       active;

	assign op = opcode_t'(fetch_data[31:26]);
	assign imm_sext = {{16{fetch_data[15]}}, fetch_data[15:0]};
	assign imm_zext = {16'h0000, fetch_data[15:0]};

	assign active = run && !halted;
	assign fetch_addr = pc;
	assign retire = active && exec_phase;
	assign status = '{halted: halted, acc: acc};

	always_ff @(posedge clk)
	begin
		if (reset || clear)
		begin
			pc <= '0;
			acc <= '0;
			halted <= 1'b0;
			exec_phase <= 1'b0;
		end
		else if (active)
		begin
			exec_phase <= !exec_phase;
			if (exec_phase)
			begin
				// fetch_data holds the word addressed by pc
				case (op)
					op_addi:
					begin
						acc <= acc + imm_sext;
						pc <= pc + 1'b1;
					end
					op_xori:
					begin
						acc <= acc ^ imm_zext;
						pc <= pc + 1'b1;
					end
					op_jmp:
						pc <= fetch_data[imem_addr_width-1:0];
					op_halt:
						halted <= 1'b1;	// pc stays on the halt word
					default:
						pc <= pc + 1'b1;	// no-op
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: instr_mem.sv
`timescale 1ns/10ps
`default_nettype none

module instr_mem #(
	parameter int imem_addr_width = 6
) (
	input  logic                       clk,
	input  mips_debug_pkg::imem_wr_t   imem_wr,
	input  logic [imem_addr_width-1:0] fetch_addr,
	output logic [31:0]                fetch_data
);

	logic [31:0] mem [2**imem_addr_width];

	always_ff @(posedge clk)
	begin
		if (imem_wr.en)
			mem[imem_wr.addr[imem_addr_width-1:0]] <= imem_wr.data;
		fetch_data <= mem[fetch_addr];	// one cycle read latency
	end

endmodule

`default_nettype wire

// File: debug_unit.sv
`timescale 1ns/10ps
`default_nettype none

module debug_unit #(
	parameter int imem_addr_width = 6
) (
	input  logic                         clk,
	input  logic                         reset,
	input  mips_debug_pkg::rx_byte_t     rx_byte,
	input  logic                         tx_busy,
	input  logic                         tx_done,
	output logic                         tx_start,
	output logic [7:0]                   tx_data,
	output mips_debug_pkg::imem_wr_t     imem_wr,
	output logic                         run,
	output logic                         clear,
	input  logic                         retire,
	input  mips_debug_pkg::core_status_t status
);

	import mips_debug_pkg::*;

	localparam int cnt_w = $clog2(report_bytes) + 1;

	typedef enum logic [2:0] {
		idle,
		programming,
		waiting,
		step_wait,
		stepping,
		continuous,
		sending
	} state_t;

	state_t                     state;
	debug_cmd_t                 cmd;
	logic [1:0]                 byte_idx;	// byte position inside the word being loaded
	logic [23:0]                word_lo;
	logic [31:0]                next_word;
	logic [imem_addr_width-1:0] load_addr;
	logic [31:0]                report_sr;
	logic [cnt_w-1:0]           report_cnt;
	logic                       report_load;	// first report byte still to launch
	logic                       from_step;

	assign cmd = debug_cmd_t'(rx_byte.data);
	assign next_word = {rx_byte.data, word_lo};

	always_ff @(posedge clk)
	begin
		tx_start <= 1'b0;
		clear <= 1'b0;
		imem_wr.en <= 1'b0;
		if (reset)
		begin
			state <= idle;
			run <= 1'b0;
			report_load <= 1'b0;
			from_step <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
					if (rx_byte.valid && cmd == cmd_start)
					begin
						clear <= 1'b1;	// fresh pc, acc and halted
						byte_idx <= '0;
						load_addr <= '0;
						state <= programming;
					end

				////////////////////////////////////////////////////////////////////
				// program load, four bytes per word, lsb first
				////////////////////////////////////////////////////////////////////
				programming:
					if (rx_byte.valid)
					begin
						byte_idx <= byte_idx + 2'd1;
						if (byte_idx == 2'd3)
						begin
							imem_wr.en <= 1'b1;
							imem_wr.addr <= 16'(load_addr);
							imem_wr.data <= next_word;
							load_addr <= load_addr + 1'b1;	// wraps past the memory depth
							if (opcode_t'(rx_byte.data[7:2]) == op_halt)
								state <= waiting;	// halt word is the last one
						end
						else
							word_lo <= {rx_byte.data, word_lo[23:8]};
					end

				waiting:
					if (rx_byte.valid)
					begin
						case (cmd)
							cmd_continuous:
							begin
								from_step <= 1'b0;
								run <= 1'b1;
								state <= continuous;
							end
							cmd_step_mode:
								state <= step_wait;
							cmd_reprogram:
								state <= idle;
							default: ;	// unknown bytes are dropped
						endcase
					end

				////////////////////////////////////////////////////////////////////
				// execution control
				////////////////////////////////////////////////////////////////////
				step_wait:
					if (rx_byte.valid && cmd == cmd_step)
					begin
						from_step <= 1'b1;
						if (status.halted)
						begin
							report_load <= 1'b1;	// nothing left to run
							state <= sending;
						end
						else
						begin
							run <= 1'b1;
							state <= stepping;
						end
					end
					else if (rx_byte.valid && cmd == cmd_reprogram)
						state <= idle;

				stepping:
					if (retire)
					begin
						run <= 1'b0;
						report_load <= 1'b1;
						state <= sending;
					end

				continuous:
					if (status.halted)
					begin
						run <= 1'b0;
						report_load <= 1'b1;
						state <= sending;
					end

				////////////////////////////////////////////////////////////////////
				// accumulator report
				////////////////////////////////////////////////////////////////////
				sending:
					if (report_load)
					begin
						if (!tx_busy)
						begin
							report_load <= 1'b0;
							tx_start <= 1'b1;
							tx_data <= status.acc[7:0];
							report_sr <= {8'h00, status.acc[31:8]};
							report_cnt <= cnt_w'(1);
						end
					end
					else if (tx_done)
					begin
						if (report_cnt == cnt_w'(report_bytes))
							state <= from_step ? step_wait : waiting;
						else
						begin
							tx_start <= 1'b1;
							tx_data <= report_sr[7:0];
							report_sr <= {8'h00, report_sr[31:8]};
							report_cnt <= report_cnt + 1'b1;
						end
					end

				default:
					state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
	parameter int clks_per_bit = 8
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx,
	output logic       tx_busy,
	output logic       tx_done
);

	localparam int cnt_w = $clog2(clks_per_bit) + 1;

	typedef enum logic [1:0] {
		idle,
		start,
		data,
		stop
	} tx_state_t;

	tx_state_t        state;
	logic [cnt_w-1:0] bit_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;
	logic             bit_end;

	assign bit_end = (bit_cnt == cnt_w'(clks_per_bit - 1));
	assign tx_busy = (state != idle);

	always_ff @(posedge clk)
	begin
		tx_done <= 1'b0;
		if (reset)
		begin
			state <= idle;
			tx <= 1'b1;
		end
		else
		begin
			bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;	// free running within a frame
			case (state)
				idle:
				begin
					tx <= 1'b1;
					bit_cnt <= '0;
					if (tx_start)
					begin
						shift <= tx_data;
						tx <= 1'b0;	// start bit from the next cycle on
						state <= start;
					end
				end
				start:
					if (bit_end)
					begin
						tx <= shift[0];
						bit_idx <= '0;
						state <= data;
					end
				data:
					if (bit_end)
					begin
						if (bit_idx == 3'd7)
						begin
							tx <= 1'b1;
							state <= stop;
						end
						else
						begin
							tx <= shift[1];
							shift <= {1'b0, shift[7:1]};
							bit_idx <= bit_idx + 3'd1;
						end
					end
				stop:
					if (bit_end)
					begin
						tx_done <= 1'b1;
						state <= idle;
					end
				default:
					state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
	parameter int clks_per_bit = 8
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     rx,
	output mips_debug_pkg::rx_byte_t rx_byte
);

	localparam int cnt_w = $clog2(clks_per_bit) + 1;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	rx_state_t        state;
	logic [1:0]       rx_sync;	// two flop synchronizer
	logic [cnt_w-1:0] bit_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;

	always_ff @(posedge clk)
	begin
		rx_sync <= {rx_sync[0], rx};
		rx_byte.valid <= 1'b0;
		if (reset)
		begin
			state <= rx_idle;
			rx_sync <= 2'b11;	// line idles high
		end
		else
		begin
			case (state)
				rx_idle:
					if (!rx_sync[1])
					begin
						bit_cnt <= '0;
						state <= rx_start;
					end
				rx_start:
					// wait half a bit to land in the middle of the start bit
					if (bit_cnt == cnt_w'(clks_per_bit / 2 - 1))
					begin
						bit_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync[1] ? rx_idle : rx_data;	// glitch, not a start bit
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				rx_data:
					if (bit_cnt == cnt_w'(clks_per_bit - 1))
					begin
						bit_cnt <= '0;
						shift <= {rx_sync[1], shift[7:1]};	// lsb first
						if (bit_idx == 3'd7)
							state <= rx_stop;
						else
							bit_idx <= bit_idx + 3'd1;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				rx_stop:
					if (bit_cnt == cnt_w'(clks_per_bit - 1))
					begin
						rx_byte.valid <= rx_sync[1];	// drop frames with a low stop bit
						rx_byte.data <= shift;
						state <= rx_idle;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				default:
					state <= rx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: mips_debug_pkg.sv
`default_nettype none

package mips_debug_pkg;

	////////////////////////////////////////////////////////////////////////////
	// instruction set of the accumulator core
	////////////////////////////////////////////////////////////////////////////

	// opcode sits in bits 31:26 of every instruction word
	typedef enum logic [5:0] {
		op_jmp  = 6'h02,
		op_addi = 6'h08,
		op_xori = 6'h0E,
		op_halt = 6'h3F
	} opcode_t;

	////////////////////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [7:0] {
		cmd_start      = 8'h01,	// followed by the program bytes
		cmd_continuous = 8'h02,
		cmd_step_mode  = 8'h03,
		cmd_reprogram  = 8'h05,
		cmd_step       = 8'h06	// only meaningful in step mode
	} debug_cmd_t;

	// one received byte, valid for a single cycle
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} rx_byte_t;

	// loader write into instruction memory
	typedef struct packed {
		logic        en;
		logic [15:0] addr;	// only the low address bits reach the memory
		logic [31:0] data;
	} imem_wr_t;

	typedef struct packed {
		logic        halted;
		logic [31:0] acc;
	} core_status_t;

	localparam int report_bytes = 4;	// accumulator, lsb first

endpackage

`default_nettype wire
